// File: hdl/chan_defines.svh
// sizes shared by the channelizer blocks
// frame size M is limited to 8..64, coefficient memory holds M * taps words
`ifndef CHAN_DEFINES_SVH
`define CHAN_DEFINES_SVH

// largest frame and its log2
`define CHAN_MAX_M 64
`define CHAN_LOG_MAX_M 6

// filter taps per phase
`define CHAN_TAPS 4
`define CHAN_COEF_DEPTH 256

`define CHAN_RESET_CNT 8
`define CHAN_DEFAULT_M 64

`endif

// File: hdl/chan_stream_pkg.sv
// sample and stream beat types
// samples are 16-bit signed I and Q, with I in the upper half of the word
`include "chan_defines.svh"

package chan_stream_pkg;

    typedef struct packed {
        logic signed [15:0] i;
        logic signed [15:0] q;
    } iq_t;

    // phase inside a frame, or bin index at the output
    typedef logic [`CHAN_LOG_MAX_M-1:0] phase_t;

    typedef struct packed {
        iq_t    sample;
        phase_t phase;
        logic   last;
    } filt_beat_t;

    typedef struct packed {
        phase_t bin;
        logic   parity;
    } out_user_t;

endpackage

// File: hdl/chan_ctrl_pkg.sv
// control and coefficient reload types
// a reload packet is one header word followed by coefficient words
`include "chan_defines.svh"

package chan_ctrl_pkg;

    typedef struct packed {
        logic [23:0]                          rsvd;
        logic [$clog2(`CHAN_COEF_DEPTH)-1:0]  addr;
    } reload_hdr_t;

    typedef struct packed {
        logic [15:0]        rsvd;
        logic signed [15:0] value;
    } reload_coef_t;

    // first word of a packet is a header, the rest are coefficients
    typedef union packed {
        reload_hdr_t  hdr;
        reload_coef_t coef;
    } reload_word_u;

    typedef struct packed {
        logic [`CHAN_LOG_MAX_M:0] m;
        logic [2:0]               log2m;
    } size_cfg_t;

endpackage

// File: hdl/chan_ctrl.sv
// frame size capture and pipeline restart
// unsupported sizes run as 64, a size of zero is ignored
`timescale 1ns/1ps
`include "chan_defines.svh"

module chan_ctrl import chan_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        sync_reset,
    input  logic [11:0] fft_size_i,
    output size_cfg_t   size_cfg_o,
    output logic        int_reset_o,
    output logic [2:0]  nfft_o
);

    logic [11:0] fft_size_s;
    logic [$clog2(`CHAN_RESET_CNT+1)-1:0] reset_cnt;

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            fft_size_s <= 12'(`CHAN_DEFAULT_M);
            reset_cnt <= ($bits(reset_cnt))'(`CHAN_RESET_CNT);
        end else if (fft_size_i != 12'd0 && fft_size_i != fft_size_s) begin
            // new size, restart the whole pipeline
            fft_size_s <= fft_size_i;
            reset_cnt <= ($bits(reset_cnt))'(`CHAN_RESET_CNT);
        end else if (reset_cnt != '0) begin
            reset_cnt <= reset_cnt - 1'b1;
        end
    end

    assign int_reset_o = (reset_cnt != '0);

    always_comb begin
        case (fft_size_s)
            12'd8: begin
                size_cfg_o.m = 7'd8;
                size_cfg_o.log2m = 3'd3;
            end
            12'd16: begin
                size_cfg_o.m = 7'd16;
                size_cfg_o.log2m = 3'd4;
            end
            12'd32: begin
                size_cfg_o.m = 7'd32;
                size_cfg_o.log2m = 3'd5;
            end
            default: begin
                size_cfg_o.m = 7'(`CHAN_DEFAULT_M);
                size_cfg_o.log2m = 3'(`CHAN_LOG_MAX_M);
            end
        endcase
    end

    assign nfft_o = size_cfg_o.log2m;

endmodule

// File: hdl/input_buffer.sv
// tags input samples with their phase and marks the frame end
// one register stage, ready is held low during the internal reset
`timescale 1ns/1ps

module input_buffer import chan_stream_pkg::*, chan_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       sync_reset,
    input  logic       int_reset_i,
    input  size_cfg_t  size_cfg_i,
    input  logic       s_valid_i,
    input  iq_t        s_data_i,
    output logic       s_ready_o,
    output logic       m_valid_o,
    output filt_beat_t m_beat_o,
    input  logic       m_ready_i
);

    phase_t phase;
    phase_t last_phase;
    logic   take;

    assign last_phase = phase_t'(size_cfg_i.m - 7'd1);
    assign s_ready_o = !int_reset_i && (!m_valid_o || m_ready_i);
    assign take = s_valid_i && s_ready_o;

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            phase <= '0;
            m_valid_o <= 1'b0;
        end else if (int_reset_i) begin
            phase <= '0;
            m_valid_o <= 1'b0;
        end else if (take) begin
            phase <= (phase == last_phase) ? '0 : phase + 1'b1;
            m_valid_o <= 1'b1;
        end else if (m_ready_i) begin
            m_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            m_beat_o.sample <= s_data_i;
            m_beat_o.phase <= phase;
            m_beat_o.last <= (phase == last_phase);
        end
    end

endmodule

// File: hdl/pfb_filter.sv
// polyphase FIR, taps per phase from the defines, latency of 3 cycles
// coefficient k of phase p sits at k*M + p, output is sum >>> 15 wrapped to 16 bits
`timescale 1ns/1ps
`include "chan_defines.svh"

module pfb_filter import chan_stream_pkg::*, chan_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         sync_reset,
    input  logic         int_reset_i,
    input  size_cfg_t    size_cfg_i,
    input  logic         s_valid_i,
    input  filt_beat_t   s_beat_i,
    output logic         s_ready_o,
    output logic         m_valid_o,
    output filt_beat_t   m_beat_o,
    input  logic         m_ready_i,
    input  logic         reload_valid_i,
    input  reload_word_u reload_data_i,
    input  logic         reload_last_i
);

    localparam int COEF_AW = $clog2(`CHAN_COEF_DEPTH);

    logic signed [15:0] coef_mem [`CHAN_COEF_DEPTH];
    iq_t                dly_mem [`CHAN_MAX_M][`CHAN_TAPS-1];
    logic [`CHAN_MAX_M-1:0][`CHAN_TAPS-2:0] dly_vld;
    logic               hdr_wait;
    logic [COEF_AW-1:0] coef_wr_addr;
    logic               en;
    logic               take;
    phase_t             ph;
    iq_t                cur_x [`CHAN_TAPS];
    iq_t                s1_x [`CHAN_TAPS];
    logic signed [15:0] s1_h [`CHAN_TAPS];
    phase_t             s1_ph;
    logic               s1_last;
    logic               s1_valid;
    logic signed [31:0] s2_pi [`CHAN_TAPS];
    logic signed [31:0] s2_pq [`CHAN_TAPS];
    phase_t             s2_ph;
    logic               s2_last;
    logic               s2_valid;
    logic signed [33:0] acc_i;
    logic signed [33:0] acc_q;

    // all stages move together, nothing moves while the output is stuck
    assign en = !m_valid_o || m_ready_i;
    assign s_ready_o = en && !int_reset_i;
    assign take = s_valid_i && s_ready_o;
    assign ph = s_beat_i.phase;

    always_comb begin
        cur_x[0] = s_beat_i.sample;
        for (int k = 1; k < `CHAN_TAPS; k++) begin
            cur_x[k] = dly_vld[ph][k-1] ? dly_mem[ph][k-1] : '0;
        end
    end

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            hdr_wait <= 1'b1;
            coef_wr_addr <= '0;
        end else if (reload_valid_i) begin
            if (hdr_wait) begin
                coef_wr_addr <= reload_data_i.hdr.addr;
            end else begin
                coef_wr_addr <= coef_wr_addr + 1'b1;
            end
            hdr_wait <= reload_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reload_valid_i && !hdr_wait) begin
            coef_mem[coef_wr_addr] <= reload_data_i.coef.value;
        end
    end

    // per-phase history, newest first
    always_ff @(posedge clk) begin
        if (take) begin
            dly_mem[ph][0] <= s_beat_i.sample;
            for (int k = 1; k < `CHAN_TAPS-1; k++) begin
                dly_mem[ph][k] <= dly_mem[ph][k-1];
            end
        end
    end

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            dly_vld <= '0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            m_valid_o <= 1'b0;
        end else if (int_reset_i) begin
            dly_vld <= '0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            m_valid_o <= 1'b0;
        end else if (en) begin
            if (take) begin
                dly_vld[ph] <= {dly_vld[ph][`CHAN_TAPS-3:0], 1'b1};
            end
            s1_valid <= take;
            s2_valid <= s1_valid;
            m_valid_o <= s2_valid;
        end
    end

    always_comb begin
        acc_i = '0;
        acc_q = '0;
        for (int k = 0; k < `CHAN_TAPS; k++) begin
            acc_i = acc_i + s2_pi[k];
            acc_q = acc_q + s2_pq[k];
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int k = 0; k < `CHAN_TAPS; k++) begin
                s1_x[k] <= cur_x[k];
                s1_h[k] <= coef_mem[COEF_AW'(k * size_cfg_i.m + ph)];
                s2_pi[k] <= s1_x[k].i * s1_h[k];
                s2_pq[k] <= s1_x[k].q * s1_h[k];
            end
            s1_ph <= ph;
            s1_last <= s_beat_i.last;
            s2_ph <= s1_ph;
            s2_last <= s1_last;
            m_beat_o.sample.i <= acc_i[30:15];
            m_beat_o.sample.q <= acc_q[30:15];
            m_beat_o.phase <= s2_ph;
            m_beat_o.last <= s2_last;
        end
    end

endmodule

// File: hdl/circ_shift.sv
// ping-pong frame buffer, odd frames leave rotated by M/2
// frames must arrive whole and in phase order, the last flag closes a frame
`timescale 1ns/1ps
`include "chan_defines.svh"

module circ_shift import chan_stream_pkg::*, chan_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       sync_reset,
    input  logic       int_reset_i,
    input  size_cfg_t  size_cfg_i,
    input  logic       s_valid_i,
    input  filt_beat_t s_beat_i,
    output logic       s_ready_o,
    output logic       m_valid_o,
    output iq_t        m_data_o,
    output phase_t     m_bin_o,
    output logic       m_last_o,
    output logic       m_parity_o,
    input  logic       m_ready_i
);

    iq_t        buf_mem [2*`CHAN_MAX_M];
    logic       wr_half;
    logic       rd_half;
    logic [1:0] full;
    phase_t     rd_cnt;
    phase_t     rd_addr;
    phase_t     last_bin;
    phase_t     half_m;
    logic       wr_take;
    logic       rd_take;

    assign last_bin = phase_t'(size_cfg_i.m - 7'd1);
    assign half_m = size_cfg_i.m[`CHAN_LOG_MAX_M:1];

    // even frames land in half 0, odd frames in half 1
    assign s_ready_o = !full[wr_half] && !int_reset_i;
    assign wr_take = s_valid_i && s_ready_o;
    assign m_valid_o = full[rd_half];
    assign rd_take = m_valid_o && m_ready_i;

    assign rd_addr = rd_half ? ((rd_cnt + half_m) & last_bin) : rd_cnt;
    assign m_data_o = buf_mem[{rd_half, rd_addr}];
    assign m_bin_o = rd_cnt;
    assign m_last_o = (rd_cnt == last_bin);
    assign m_parity_o = rd_half;

    always_ff @(posedge clk) begin
        if (wr_take) begin
            buf_mem[{wr_half, s_beat_i.phase}] <= s_beat_i.sample;
        end
    end

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            wr_half <= 1'b0;
            rd_half <= 1'b0;
            full <= 2'b00;
            rd_cnt <= '0;
        end else if (int_reset_i) begin
            wr_half <= 1'b0;
            rd_half <= 1'b0;
            full <= 2'b00;
            rd_cnt <= '0;
        end else begin
            if (wr_take && s_beat_i.last) begin
                full[wr_half] <= 1'b1;
                wr_half <= ~wr_half;
            end
            if (rd_take && m_last_o) begin
                full[rd_half] <= 1'b0;
                rd_half <= ~rd_half;
                rd_cnt <= '0;
            end else if (rd_take) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/downselect.sv
// bin mask and packet framing on the output stream
// mask words load in order, bins 0-31 first; payload length 0 acts as 1
`timescale 1ns/1ps
`include "chan_defines.svh"

module downselect import chan_stream_pkg::*; (
    input  logic        clk,
    input  logic        sync_reset,
    input  logic        int_reset_i,
    input  logic        s_valid_i,
    input  iq_t         s_data_i,
    input  phase_t      s_bin_i,
    input  logic        s_parity_i,
    output logic        s_ready_o,
    input  logic [15:0] payload_length_i,
    input  logic        select_valid_i,
    input  logic [31:0] select_data_i,
    input  logic        select_last_i,
    output logic        select_ready_o,
    output logic        m_valid_o,
    output iq_t         m_data_o,
    output out_user_t   m_user_o,
    output logic        m_last_o,
    input  logic        m_ready_i
);

    logic [`CHAN_MAX_M-1:0] mask;
    logic        sel_word;
    logic [15:0] beat_cnt;
    logic [15:0] len_eff;
    logic        keep;
    logic        take;
    logic        pkt_end;

    assign keep = mask[s_bin_i];
    // masked bins are always consumed
    assign s_ready_o = !int_reset_i && (!keep || !m_valid_o || m_ready_i);
    assign take = s_valid_i && s_ready_o;
    assign select_ready_o = !int_reset_i;
    assign len_eff = (payload_length_i == 16'd0) ? 16'd1 : payload_length_i;
    assign pkt_end = (beat_cnt == len_eff - 16'd1);

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            mask <= '1;
            sel_word <= 1'b0;
        end else if (select_valid_i && select_ready_o) begin
            mask[sel_word*32 +: 32] <= select_data_i;
            sel_word <= select_last_i ? 1'b0 : ~sel_word;
        end
    end

    always_ff @(posedge clk, posedge sync_reset) begin
        if (sync_reset) begin
            m_valid_o <= 1'b0;
            beat_cnt <= '0;
        end else if (int_reset_i) begin
            m_valid_o <= 1'b0;
            beat_cnt <= '0;
        end else if (take && keep) begin
            m_valid_o <= 1'b1;
            beat_cnt <= pkt_end ? 16'd0 : beat_cnt + 16'd1;
        end else if (m_ready_i) begin
            m_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && keep) begin
            m_data_o <= s_data_i;
            m_user_o.bin <= s_bin_i;
            m_user_o.parity <= s_parity_i;
            m_last_o <= pkt_end;
        end
    end

endmodule

// File: hdl/channelizer_top.sv
// M/2 channelizer front end without the FFT, critically sampled input
// reload port has no ready, it must never be throttled
`timescale 1ns/1ps

module channelizer_top import chan_stream_pkg::*, chan_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         sync_reset,
    input  logic         s_valid_i,
    input  iq_t          s_data_i,
    output logic         s_ready_o,
    input  logic         reload_valid_i,
    input  reload_word_u reload_data_i,
    input  logic         reload_last_i,
    input  logic         select_valid_i,
    input  logic [31:0]  select_data_i,
    input  logic         select_last_i,
    output logic         select_ready_o,
    input  logic [11:0]  fft_size_i,
    input  logic [15:0]  payload_length_i,
    output logic         m_valid_o,
    output iq_t          m_data_o,
    output out_user_t    m_user_o,
    output logic         m_last_o,
    input  logic         m_ready_i,
    output logic [2:0]   nfft_o
);

    size_cfg_t  size_cfg;
    logic       int_reset;
    logic       buf_valid;
    logic       buf_ready;
    filt_beat_t buf_beat;
    logic       pfb_valid;
    logic       pfb_ready;
    filt_beat_t pfb_beat;
    logic       circ_valid;
    logic       circ_ready;
    iq_t        circ_data;
    phase_t     circ_bin;
    logic       circ_parity;

    chan_ctrl u_chan_ctrl (
        .clk(clk),
        .sync_reset(sync_reset),
        .fft_size_i(fft_size_i),
        .size_cfg_o(size_cfg),
        .int_reset_o(int_reset),
        .nfft_o(nfft_o)
    );

    input_buffer u_input_buffer (
        .clk(clk),
        .sync_reset(sync_reset),
        .int_reset_i(int_reset),
        .size_cfg_i(size_cfg),
        .s_valid_i(s_valid_i),
        .s_data_i(s_data_i),
        .s_ready_o(s_ready_o),
        .m_valid_o(buf_valid),
        .m_beat_o(buf_beat),
        .m_ready_i(buf_ready)
    );

    pfb_filter u_pfb (
        .clk(clk),
        .sync_reset(sync_reset),
        .int_reset_i(int_reset),
        .size_cfg_i(size_cfg),
        .s_valid_i(buf_valid),
        .s_beat_i(buf_beat),
        .s_ready_o(buf_ready),
        .m_valid_o(pfb_valid),
        .m_beat_o(pfb_beat),
        .m_ready_i(pfb_ready),
        .reload_valid_i(reload_valid_i),
        .reload_data_i(reload_data_i),
        .reload_last_i(reload_last_i)
    );

    // frame end is not needed past the shifter, bins carry the position
    circ_shift u_circ_shift (
        .clk(clk),
        .sync_reset(sync_reset),
        .int_reset_i(int_reset),
        .size_cfg_i(size_cfg),
        .s_valid_i(pfb_valid),
        .s_beat_i(pfb_beat),
        .s_ready_o(pfb_ready),
        .m_valid_o(circ_valid),
        .m_data_o(circ_data),
        .m_bin_o(circ_bin),
        .m_last_o(),
        .m_parity_o(circ_parity),
        .m_ready_i(circ_ready)
    );

    downselect u_downselect (
        .clk(clk),
        .sync_reset(sync_reset),
        .int_reset_i(int_reset),
        .s_valid_i(circ_valid),
        .s_data_i(circ_data),
        .s_bin_i(circ_bin),
        .s_parity_i(circ_parity),
        .s_ready_o(circ_ready),
        .payload_length_i(payload_length_i),
        .select_valid_i(select_valid_i),
        .select_data_i(select_data_i),
        .select_last_i(select_last_i),
        .select_ready_o(select_ready_o),
        .m_valid_o(m_valid_o),
        .m_data_o(m_data_o),
        .m_user_o(m_user_o),
        .m_last_o(m_last_o),
        .m_ready_i(m_ready_i)
    );

endmodule

// File: verif/channelizer_tb.sv
// directed tests for the channelizer front end, with a frame level reference model
// the model needs the pipeline idle before a size, mask or payload length change
`timescale 1ns/1ps
`include "chan_defines.svh"

module channelizer_tb import chan_stream_pkg::*, chan_ctrl_pkg::*; ();

    typedef struct packed {
        iq_t       data;
        out_user_t user;
        logic      last;
    } out_beat_t;

    logic         clk;
    logic         sync_reset;
    logic         s_valid_i;
    iq_t          s_data_i;
    logic         s_ready_o;
    logic         reload_valid_i;
    reload_word_u reload_data_i;
    logic         reload_last_i;
    logic         select_valid_i;
    logic [31:0]  select_data_i;
    logic         select_last_i;
    logic         select_ready_o;
    logic [11:0]  fft_size_i;
    logic [15:0]  payload_length_i;
    logic         m_valid_o;
    iq_t          m_data_o;
    out_user_t    m_user_o;
    logic         m_last_o;
    logic         m_ready_i;
    logic [2:0]   nfft_o;

    // reference model state
    logic signed [15:0] coefs [`CHAN_COEF_DEPTH];
    iq_t                hist [`CHAN_MAX_M][`CHAN_TAPS];
    iq_t                frames [8][`CHAN_MAX_M];
    out_beat_t          exp_q [$];
    int                 cur_m;
    logic               parity;
    int                 out_cnt;
    int                 pay_len;
    logic [63:0]        mask;

    logic [15:0] lfsr;
    logic        bp_on;
    int          errors;
    int          checks;
    out_beat_t   held_beat;
    logic        held;

    channelizer_top channelizer_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand16();
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < 16; b++) begin
            v = {v[14:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
        finish_run();
    endtask

    // random back-pressure from one LFSR bit per cycle
    always @(posedge clk) begin
        m_ready_i <= bp_on ? lfsr_bit() : 1'b1;
    end

    // output monitor that compares every transferred beat with the model
    always @(posedge clk) begin
        out_beat_t cur;
        out_beat_t want;
        if (!sync_reset) begin
            cur = {m_data_o, m_user_o, m_last_o};
            if (held) begin
                checks++;
                if (!m_valid_o || cur !== held_beat) begin
                    errors++;
                    $display("Fail at %0t ns: beat changed under back-pressure, held %h now %h",
                             $time, held_beat, cur);
                end
            end
            if (m_valid_o && m_ready_i) begin
                checks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected output beat %h at %0t ns", cur, $time);
                end else begin
                    want = exp_q.pop_front();
                    if (cur !== want) begin
                        errors++;
                        $display("Fail at %0t ns: output beat expected %h got %h",
                                 $time, want, cur);
                    end
                end
            end
            held = m_valid_o && !m_ready_i;
            held_beat = cur;
        end
    end

    // filter, rotate and mask one frame as the output should show it
    task automatic model_frame(input int f);
        iq_t       y [`CHAN_MAX_M];
        longint    acc_i;
        longint    acc_q;
        int        src;
        out_beat_t beat;
        for (int p = 0; p < cur_m; p++) begin
            for (int k = `CHAN_TAPS - 1; k > 0; k--) begin
                hist[p][k] = hist[p][k-1];
            end
            hist[p][0] = frames[f][p];
            acc_i = 0;
            acc_q = 0;
            for (int k = 0; k < `CHAN_TAPS; k++) begin
                acc_i += longint'(coefs[k*cur_m+p]) * longint'(hist[p][k].i);
                acc_q += longint'(coefs[k*cur_m+p]) * longint'(hist[p][k].q);
            end
            y[p].i = 16'(acc_i >>> 15);
            y[p].q = 16'(acc_q >>> 15);
        end
        for (int b = 0; b < cur_m; b++) begin
            src = parity ? (b + cur_m / 2) % cur_m : b;
            if (mask[b]) begin
                beat.data = y[src];
                beat.user.bin = phase_t'(b);
                beat.user.parity = parity;
                beat.last = (out_cnt == pay_len - 1);
                out_cnt = beat.last ? 0 : out_cnt + 1;
                exp_q.push_back(beat);
            end
        end
        parity = ~parity;
    endtask

    task automatic gen_frames(input int n);
        for (int f = 0; f < n; f++) begin
            for (int p = 0; p < cur_m; p++) begin
                frames[f][p].i = rand16();
                frames[f][p].q = rand16();
            end
        end
    endtask

    task automatic send_frames(input int n);
        int wait_cnt;
        for (int f = 0; f < n; f++) begin
            model_frame(f);
            for (int p = 0; p < cur_m; p++) begin
                s_valid_i <= 1'b1;
                s_data_i <= frames[f][p];
                wait_cnt = 0;
                @(posedge clk);
                while (!s_ready_o) begin
                    wait_cnt++;
                    if (wait_cnt > 2000) begin
                        timed_out("input ready");
                    end
                    @(posedge clk);
                end
            end
        end
        s_valid_i <= 1'b0;
    endtask

    task automatic drain();
        int wait_cnt;
        wait_cnt = 0;
        while (exp_q.size() != 0) begin
            wait_cnt++;
            if (wait_cnt > 5000) begin
                timed_out("the expected output beats");
            end
            @(posedge clk);
        end
    endtask

    // header at address 0 followed by count random coefficients
    task automatic load_coefs(input int count);
        logic [15:0] c;
        reload_valid_i <= 1'b1;
        reload_data_i <= 32'h0000_0000;
        reload_last_i <= 1'b0;
        @(posedge clk);
        for (int a = 0; a < count; a++) begin
            c = rand16();
            coefs[a] = c;
            reload_data_i <= {16'h0000, c};
            reload_last_i <= (a == count - 1);
            @(posedge clk);
        end
        reload_valid_i <= 1'b0;
        reload_last_i <= 1'b0;
    endtask

    task automatic load_mask(input logic [63:0] m);
        int wait_cnt;
        for (int w = 0; w < 2; w++) begin
            select_valid_i <= 1'b1;
            select_data_i <= m[w*32 +: 32];
            select_last_i <= (w == 1);
            wait_cnt = 0;
            @(posedge clk);
            while (!select_ready_o) begin
                wait_cnt++;
                if (wait_cnt > 100) begin
                    timed_out("select ready");
                end
                @(posedge clk);
            end
        end
        select_valid_i <= 1'b0;
        select_last_i <= 1'b0;
        mask = m;
    endtask

    task automatic restart_size(input int m, input logic [2:0] log2m);
        int wait_cnt;
        int low;
        fft_size_i <= 12'(m);
        wait_cnt = 0;
        @(posedge clk);
        while (nfft_o !== log2m) begin
            wait_cnt++;
            if (wait_cnt > 100) begin
                timed_out("the new nfft value");
            end
            @(posedge clk);
        end
        low = 0;
        while (!s_ready_o) begin
            low++;
            if (low > 100) begin
                timed_out("input ready after the size change");
            end
            @(posedge clk);
        end
        checks++;
        if (low != `CHAN_RESET_CNT) begin
            errors++;
            $display("Fail at %0t ns: internal reset lasted %0d cycles after resize",
                     $time, low);
        end
        // restart empties the delay lines and the frame parity
        cur_m = m;
        parity = 1'b0;
        out_cnt = 0;
        for (int p = 0; p < `CHAN_MAX_M; p++) begin
            for (int k = 0; k < `CHAN_TAPS; k++) begin
                hist[p][k] = '0;
            end
        end
    endtask

    task automatic reset_sequence();
        int low;
        repeat (2) begin
            @(posedge clk);
            checks++;
            if (m_valid_o !== 1'b0 || s_ready_o !== 1'b0 || select_ready_o !== 1'b0) begin
                errors++;
                $display("Fail at %0t ns: stream valid or ready high in reset", $time);
            end
        end
        sync_reset <= 1'b0;
        low = 0;
        @(posedge clk);
        while (!s_ready_o) begin
            low++;
            checks++;
            if (m_valid_o !== 1'b0 || select_ready_o !== 1'b0) begin
                errors++;
                $display("Fail at %0t ns: output active in internal reset", $time);
            end
            if (low > 100) begin
                timed_out("the end of the internal reset");
            end
            @(posedge clk);
        end
        checks++;
        if (low != `CHAN_RESET_CNT || nfft_o !== 3'd6) begin
            errors++;
            $display("Fail at %0t ns: internal reset %0d cycles, nfft %0d", $time, low, nfft_o);
        end
    endtask

    task automatic impulse_response();
        restart_size(8, 3'd3);
        load_coefs(8 * `CHAN_TAPS);
        for (int p = 0; p < cur_m; p++) begin
            frames[0][p] = {16'sh4000, -16'sh2000};
        end
        for (int f = 1; f < 5; f++) begin
            for (int p = 0; p < cur_m; p++) begin
                frames[f][p] = '0;
            end
        end
        send_frames(5);
        drain();
    endtask

    task automatic rotation_frames();
        gen_frames(6);
        send_frames(6);
        drain();
    endtask

    task automatic mask_and_packets();
        load_mask(64'h0000_0000_0000_00a5);
        payload_length_i <= 16'd3;
        pay_len = 3;
        gen_frames(4);
        send_frames(4);
        drain();
        load_mask('1);
    endtask

    task automatic random_backpressure();
        gen_frames(6);
        bp_on <= 1'b1;
        send_frames(6);
        drain();
        bp_on <= 1'b0;
    endtask

    task automatic size_change();
        restart_size(32, 3'd5);
        load_coefs(32 * `CHAN_TAPS);
        gen_frames(3);
        send_frames(3);
        drain();
    endtask

    initial begin
        sync_reset = 1'b1;
        s_valid_i = 1'b0;
        s_data_i = '0;
        reload_valid_i = 1'b0;
        reload_data_i = '0;
        reload_last_i = 1'b0;
        select_valid_i = 1'b0;
        select_data_i = '0;
        select_last_i = 1'b0;
        fft_size_i = 12'd64;
        payload_length_i = 16'd1;
        m_ready_i = 1'b1;
        lfsr = 16'd3250;
        bp_on = 1'b0;
        errors = 0;
        checks = 0;
        held = 1'b0;
        held_beat = '0;
        cur_m = 64;
        parity = 1'b0;
        out_cnt = 0;
        pay_len = 1;
        mask = '1;

        reset_sequence();
        impulse_response();
        rotation_frames();
        mask_and_packets();
        random_backpressure();
        size_change();
        finish_run();
    end

endmodule

// File: all.f
+incdir+hdl
hdl/chan_stream_pkg.sv
hdl/chan_ctrl_pkg.sv
hdl/chan_ctrl.sv
hdl/input_buffer.sv
hdl/pfb_filter.sv
hdl/circ_shift.sv
hdl/downselect.sv
hdl/channelizer_top.sv
verif/channelizer_tb.sv

// File: Makefile
TOP = channelizer_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module channelizer_top

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
